// File: src/sm2_red_pkg.sv
// field constants, apb register map and stage payload types, imported by every engine module
`default_nettype none

package sm2_red_pkg;

    // word geometry
    localparam int WORD_W     = 32;
    localparam int ELEM_WORDS = 8;
    localparam int PROD_WORDS = 16;
    localparam int ELEM_W     = WORD_W * ELEM_WORDS;

    // biased fold sum, eight estimate bits sit above the element
    localparam int SUM_W = 264;
    localparam int EST_W = SUM_W - ELEM_W;
    // coarse value is below 3p
    localparam int CRS_W = ELEM_W + 2;
    // 14 doubled/single terms plus one p of bias stay under 15 * 2^256
    localparam int EST_MAX = 14;

    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [ELEM_W-1:0]       elem_t;
    typedef word_t [PROD_WORDS-1:0]  prod_t;
    typedef logic [SUM_W-1:0]        sum_t;
    typedef logic [EST_MAX:0][SUM_W-1:0] p_mult_t;

    // p = 2^256 - 2^224 - 2^96 + 2^64 - 1
    localparam elem_t SM2_P =
        256'hFFFFFFFE_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_00000000_FFFFFFFF_FFFFFFFF;

    // k * p for every estimate, built by repeated addition
    function automatic p_mult_t gen_p_mult();
        p_mult_t tbl;
        sum_t    acc;
        acc = '0;
        for (int k = 0; k <= EST_MAX; k++) begin
            tbl[k] = acc;
            acc    = acc + sum_t'(SM2_P);
        end
        return tbl;
    endfunction

    localparam p_mult_t P_MULT = gen_p_mult();
    // one p outweighs the four subtracted middle-word terms (each below 2^96)
    localparam sum_t FOLD_BIAS = sum_t'(SM2_P);

    // stage payloads, valid travels with the data
    typedef struct packed {
        logic valid;
        sum_t sum;
    } fold_out_t;

    typedef struct packed {
        logic             valid;
        logic [CRS_W-1:0] value;
    } coarse_out_t;

    typedef struct packed {
        logic  valid;
        elem_t elem;
    } res_out_t;

    // apb register map, byte addresses
    localparam logic [7:0] ADDR_OP_BASE  = 8'h00;
    localparam logic [7:0] ADDR_CTRL     = 8'h40;
    localparam logic [7:0] ADDR_STATUS   = 8'h44;
    localparam logic [7:0] ADDR_RES_BASE = 8'h80;

    localparam int CTRL_START_BIT  = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

`default_nettype wire

// File: src/sm2_red_ctrl.sv
// apb register file and job sequencing; launches one reduction and captures its result
`timescale 1ns/1ps
`default_nettype none

module sm2_red_ctrl
    import sm2_red_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [7:0] paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    output prod_t      op,
    output logic       launch,
    input  res_out_t   res
);

    localparam int OP_IDX_W  = $clog2(PROD_WORDS);
    localparam int RES_IDX_W = $clog2(ELEM_WORDS);

    prod_t                  op_q;
    word_t [ELEM_WORDS-1:0] res_q;
    logic                   busy;
    logic                   done;

    logic                 access;
    logic [7:0]           op_off;
    logic [7:0]           res_off;
    logic                 op_hit;
    logic                 res_hit;
    logic                 ctrl_hit;
    logic                 stat_hit;
    logic                 map_hit;
    logic [OP_IDX_W-1:0]  op_idx;
    logic [RES_IDX_W-1:0] res_idx;
    logic                 start_req;

    // access phase, zero wait states
    assign access = psel & penable;
    assign pready = 1'b1;

    // address decode, word aligned windows only
    assign op_off   = paddr - ADDR_OP_BASE;
    assign res_off  = paddr - ADDR_RES_BASE;
    assign op_hit   = (paddr[1:0] == 2'b00) && (op_off < 8'(PROD_WORDS * 4));
    assign res_hit  = (paddr[1:0] == 2'b00) && (res_off < 8'(ELEM_WORDS * 4));
    assign ctrl_hit = (paddr == ADDR_CTRL);
    assign stat_hit = (paddr == ADDR_STATUS);
    assign map_hit  = op_hit | res_hit | ctrl_hit | stat_hit;
    assign op_idx   = op_off[OP_IDX_W+1:2];
    assign res_idx  = res_off[RES_IDX_W+1:2];

    // start accepted only when idle
    assign start_req = access & pwrite & ctrl_hit & pwdata[CTRL_START_BIT];
    assign launch    = start_req & ~busy;

    // error cases: unmapped, result write, start while busy
    assign pslverr = access & (~map_hit | (pwrite & res_hit) | (start_req & busy));

    // read mux, ctrl reads back as zero
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            if (op_hit) begin
                prdata = op_q[op_idx];
            end else if (res_hit) begin
                prdata = res_q[res_idx];
            end else if (stat_hit) begin
                prdata[STATUS_BUSY_BIT] = busy;
                prdata[STATUS_DONE_BIT] = done;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q  <= '0;
            res_q <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            // operand words stay writable, fold samples them on launch
            if (access && pwrite && op_hit) begin
                op_q[op_idx] <= pwdata;
            end
            if (launch) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (busy && res.valid) begin
                // result lands three cycles after launch
                res_q <= res.elem;
                busy  <= 1'b0;
                done  <= 1'b1;
            end
        end
    end

    assign op = op_q;

endmodule

`default_nettype wire

// File: src/sm2_word_fold.sv
// first stage: biased sm2 word-placement sum of the 512-bit product, registered
`timescale 1ns/1ps
`default_nettype none

module sm2_word_fold
    import sm2_red_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  prod_t     op,
    input  logic      launch,
    output fold_out_t fold
);

    localparam word_t ZW = '0;

    elem_t t0, t1, t2, t3;
    elem_t t4, t5, t6, t7, t8, t9;
    sum_t  dbl_sum;
    sum_t  sgl_sum;
    sum_t  mid_sub;
    sum_t  sum_d;
    logic  valid_q;
    sum_t  sum_q;

    // doubled terms, high word first
    assign t0 = {op[15], ZW, op[15], op[14], op[13], ZW, op[15], op[14]};
    assign t1 = {op[14], ZW, ZW, ZW, ZW, ZW, op[14], op[13]};
    assign t2 = {op[13], ZW, ZW, ZW, ZW, ZW, ZW, op[15]};
    assign t3 = {op[12], ZW, ZW, ZW, ZW, ZW, ZW, ZW};
    // single terms, t9 is the low half as is
    assign t4 = {op[15], op[15], op[14], op[13], op[12], ZW, op[11], op[10]};
    assign t5 = {op[11], op[14], op[13], op[12], op[11], ZW, op[10], op[9]};
    assign t6 = {op[10], op[11], op[10], op[9], op[8], ZW, op[13], op[12]};
    assign t7 = {op[9], ZW, ZW, op[15], op[14], ZW, op[9], op[8]};
    assign t8 = {op[8], ZW, ZW, ZW, op[15], ZW, op[12], op[11]};
    assign t9 = op[ELEM_WORDS-1:0];

    assign dbl_sum = sum_t'(t0) + sum_t'(t1) + sum_t'(t2) + sum_t'(t3);
    assign sgl_sum = sum_t'(t4) + sum_t'(t5) + sum_t'(t6) + sum_t'(t7) + sum_t'(t8) +
                     sum_t'(t9);

    // negative terms all sit in word 2
    assign mid_sub = (sum_t'(op[8]) + sum_t'(op[9]) + sum_t'(op[13]) + sum_t'(op[14]))
                     << (2 * WORD_W);

    // bias keeps the sum positive
    assign sum_d = (dbl_sum << 1) + sgl_sum - mid_sub + FOLD_BIAS;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= launch;
        end
    end

    always_ff @(posedge clk) begin
        sum_q <= sum_d;
    end

    assign fold = '{valid: valid_q, sum: sum_q};

endmodule

`default_nettype wire

// File: src/sm2_coarse_reduce.sv
// second stage: removes k * p where k is the fold sum above bit 255, registered
`timescale 1ns/1ps
`default_nettype none

module sm2_coarse_reduce
    import sm2_red_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  fold_out_t   fold,
    output coarse_out_t coarse
);

    logic [EST_W-1:0] est;
    sum_t             mult;
    sum_t             diff;
    logic             valid_q;
    logic [CRS_W-1:0] value_q;

    // estimate never exceeds EST_MAX
    assign est = fold.sum[SUM_W-1:ELEM_W];

    // table lookup of k * p
    always_comb begin
        mult = '0;
        for (int k = 0; k <= EST_MAX; k++) begin
            if (est == EST_W'(k)) begin
                mult = P_MULT[k];
            end
        end
    end

    // k * p <= k * 2^256 <= sum, so no borrow
    assign diff = fold.sum - mult;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fold.valid;
        end
    end

    // leftover is low part plus k * (2^256 - p), well under 3p
    always_ff @(posedge clk) begin
        value_q <= diff[CRS_W-1:0];
    end

    assign coarse = '{valid: valid_q, value: value_q};

endmodule

`default_nettype wire

// File: src/sm2_final_correct.sv
// third stage: subtracts 0, p or 2p to land in 0..p-1, registered
`timescale 1ns/1ps
`default_nettype none

module sm2_final_correct
    import sm2_red_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  coarse_out_t coarse,
    output res_out_t    res
);

    logic [CRS_W:0] ext;
    logic [CRS_W:0] sub1;
    logic [CRS_W:0] sub2;
    elem_t          elem_d;
    logic           valid_q;
    elem_t          elem_q;

    // one spare bit as borrow flag
    assign ext  = {1'b0, coarse.value};
    assign sub1 = ext - (CRS_W + 1)'(SM2_P);
    assign sub2 = ext - (CRS_W + 1)'(P_MULT[2]);

    // smallest candidate without borrow
    always_comb begin
        if (!sub2[CRS_W]) begin
            elem_d = sub2[ELEM_W-1:0];
        end else if (!sub1[CRS_W]) begin
            elem_d = sub1[ELEM_W-1:0];
        end else begin
            elem_d = ext[ELEM_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= coarse.valid;
        end
    end

    always_ff @(posedge clk) begin
        elem_q <= elem_d;
    end

    assign res = '{valid: valid_q, elem: elem_q};

endmodule

`default_nettype wire

// File: src/sm2_red_top.sv
// engine top: apb register block feeding the fold, coarse and final reduction stages
`timescale 1ns/1ps
`default_nettype none

module sm2_red_top
    import sm2_red_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [7:0] paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr
);

    // stage-to-stage payloads
    prod_t       op;
    logic        launch;
    fold_out_t   fold;
    coarse_out_t coarse;
    res_out_t    res;

    sm2_red_ctrl sm2_red_ctrl_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .op      (op),
        .launch  (launch),
        .res     (res)
    );

    sm2_word_fold sm2_word_fold_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .op     (op),
        .launch (launch),
        .fold   (fold)
    );

    sm2_coarse_reduce sm2_coarse_reduce_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .fold   (fold),
        .coarse (coarse)
    );

    sm2_final_correct sm2_final_correct_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .coarse (coarse),
        .res    (res)
    );

endmodule

`default_nettype wire

// File: bench/sm2_red_clkgen.sv
// testbench clock source, free-running 4 ns period from time zero
`timescale 1ns/1ps
`default_nettype none

module sm2_red_clkgen (
    output logic clk
);

    // half of the 4 ns period
    localparam int HALF_NS = 2;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_NS) clk = ~clk;

endmodule

`default_nettype wire

// File: bench/sm2_red_chk.sv
// concurrent assertions on the control module, attached to sm2_red_ctrl by bind from the testbench
`timescale 1ns/1ps
`default_nettype none

module sm2_red_chk
    import sm2_red_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic pready,
    input logic launch,
    input logic busy,
    input logic done
);

    // zero wait states on every access
    pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready went low");

    // single-cycle launch pulse
    launch_pulse: assert property (@(posedge clk) disable iff (!rst_n) $past(launch) |-> !launch)
        else $error("launch stayed high for more than one cycle");

    // done is set on the third edge after launch, so first sampled four edges later
    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(launch, 4))
        else $error("done rose without a launch three cycles earlier");

    // flags are exclusive
    busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n) !(busy && done))
        else $error("busy and done high together");

endmodule

`default_nettype wire

// File: bench/sm2_red_tb.sv
// testbench for the sm2 reduction engine, drives the apb port from a table of operands
`timescale 1ns/1ps
`default_nettype none

module sm2_red_tb
    import sm2_red_pkg::*;
();

    localparam int NUM_FIXED    = 6;
    localparam int NUM_ROWS     = 16;
    localparam int CLK_NS       = 4;
    localparam int POLL_LIMIT   = 16;
    // operand writes, operand reads, start, two status reads, result reads
    localparam int ROW_XFERS    = 2 * PROD_WORDS + ELEM_WORDS + 3;
    // two cycles per transfer, plus status lag and slack
    localparam int ROW_CYCLES   = 2 * ROW_XFERS + 4;
    // reset, reset reads and the error section
    localparam int EXTRA_CYCLES = 200;
    localparam int WATCHDOG_NS  = (NUM_ROWS * ROW_CYCLES + EXTRA_CYCLES) * CLK_NS;
    localparam logic [31:0] SEED = 32'd81088;

    // p = 2^256 - 2^224 - 2^96 + 2^64 - 1, in product width
    localparam logic [511:0] P_WIDE = (512'd1 << 256) - (512'd1 << 224) - (512'd1 << 96) +
                                      (512'd1 << 64) - 512'd1;

    logic       clk;
    logic       rst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] paddr;
    word_t      pwdata;
    word_t      prdata;
    logic       pready;
    logic       pslverr;

    // stimulus and expected values
    prod_t op_tbl [NUM_ROWS];
    elem_t exp_tbl [NUM_ROWS];

    sm2_red_clkgen sm2_red_clkgen_i (
        .clk (clk)
    );

    sm2_red_top sm2_red_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind sm2_red_ctrl sm2_red_chk sm2_red_chk_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .pready (pready),
        .launch (launch),
        .busy   (busy),
        .done   (done)
    );

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_elem(input string what, input elem_t got, input elem_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // 32-bit lcg, numerical recipes constants
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // called on a falling edge, returns on the falling edge after the access phase
    task automatic apb_write(input logic [7:0] addr, input word_t data, output logic err);
        psel    = 1'b1;
        pwrite  = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        // mid low phase, inputs settled
        #1;
        err = pslverr;
        check_flag("pready in write access phase", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output word_t data, output logic err);
        psel    = 1'b1;
        pwrite  = 1'b0;
        penable = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        check_flag("pready in read access phase", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // accesses that must not raise pslverr
    task automatic write_reg(input logic [7:0] addr, input word_t data);
        logic err;
        apb_write(addr, data, err);
        check_flag($sformatf("pslverr on write to %02h", addr), err, 1'b0);
    endtask

    task automatic read_reg(input logic [7:0] addr, output word_t data);
        logic err;
        apb_read(addr, data, err);
        check_flag($sformatf("pslverr on read of %02h", addr), err, 1'b0);
    endtask

    task automatic read_result(output elem_t got);
        word_t rd;
        for (int w = 0; w < ELEM_WORDS; w++) begin
            read_reg(ADDR_RES_BASE + 8'(4 * w), rd);
            got[WORD_W*w +: WORD_W] = rd;
        end
    endtask

    // poll status until done, bounded
    task automatic wait_done();
        word_t rd;
        int    polls;
        rd    = '0;
        polls = 0;
        while (!rd[STATUS_DONE_BIT] && polls < POLL_LIMIT) begin
            read_reg(ADDR_STATUS, rd);
            polls++;
        end
        if (!rd[STATUS_DONE_BIT]) begin
            $display("done flag still low after %0d status reads", polls);
            abort_run();
        end
    endtask

    task automatic fill_table();
        logic [511:0] wide;
        logic [511:0] rem;
        logic [31:0]  state;
        state     = SEED;
        op_tbl[0] = '0;
        op_tbl[1] = P_WIDE;
        op_tbl[2] = P_WIDE * P_WIDE;
        op_tbl[3] = 512'd1 << 256;
        op_tbl[4] = '1;
        // only the middle eight words set
        op_tbl[5] = '0;
        for (int w = 4; w < 12; w++) begin
            op_tbl[5][w] = '1;
        end
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            for (int w = 0; w < PROD_WORDS; w++) begin
                state        = lcg_step(state);
                op_tbl[r][w] = state;
            end
        end
        // reference result straight from the modulus
        for (int r = 0; r < NUM_ROWS; r++) begin
            wide       = op_tbl[r];
            rem        = wide % P_WIDE;
            exp_tbl[r] = rem[ELEM_W-1:0];
        end
    endtask

    task automatic run_row(input int row);
        word_t rd;
        elem_t got;
        int    lag;
        for (int w = 0; w < PROD_WORDS; w++) begin
            write_reg(ADDR_OP_BASE + 8'(4 * w), op_tbl[row][w]);
        end
        for (int w = 0; w < PROD_WORDS; w++) begin
            read_reg(ADDR_OP_BASE + 8'(4 * w), rd);
            check_word($sformatf("row %0d operand word %0d", row, w), rd, op_tbl[row][w]);
        end
        // lag 0 samples status one and three cycles after launch, lag 1 two and four
        lag = row % 2;
        write_reg(ADDR_CTRL, word_t'(1));
        repeat (lag) @(negedge clk);
        read_reg(ADDR_STATUS, rd);
        check_flag($sformatf("row %0d busy after start", row), rd[STATUS_BUSY_BIT], 1'b1);
        check_flag($sformatf("row %0d done after start", row), rd[STATUS_DONE_BIT], 1'b0);
        read_reg(ADDR_STATUS, rd);
        check_flag($sformatf("row %0d busy at finish", row), rd[STATUS_BUSY_BIT], 1'b0);
        check_flag($sformatf("row %0d done at finish", row), rd[STATUS_DONE_BIT], 1'b1);
        read_result(got);
        check_elem($sformatf("row %0d result", row), got, exp_tbl[row]);
    endtask

    task automatic check_error_responses();
        word_t rd;
        word_t saved;
        elem_t got;
        logic  err;
        int    pick;
        pick = NUM_FIXED;
        // gap between status and result window
        apb_read(8'h48, rd, err);
        check_flag("pslverr on unmapped read", err, 1'b1);
        // result words are read only
        read_reg(ADDR_RES_BASE, saved);
        apb_write(ADDR_RES_BASE, ~saved, err);
        check_flag("pslverr on result write", err, 1'b1);
        read_reg(ADDR_RES_BASE, rd);
        check_word("result word after rejected write", rd, saved);
        // load an operand whose result differs from the one held now
        for (int w = 0; w < PROD_WORDS; w++) begin
            write_reg(ADDR_OP_BASE + 8'(4 * w), op_tbl[pick][w]);
        end
        // second start reaches its access phase two cycles into the job
        write_reg(ADDR_CTRL, word_t'(1));
        apb_write(ADDR_CTRL, word_t'(1), err);
        check_flag("pslverr on start while busy", err, 1'b1);
        wait_done();
        // nothing queued behind the running job
        read_reg(ADDR_STATUS, rd);
        check_flag("busy after rejected start", rd[STATUS_BUSY_BIT], 1'b0);
        read_result(got);
        check_elem("result after rejected start", got, exp_tbl[pick]);
    endtask

    // run limit from the table length
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        word_t rd;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        fill_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // reset state
        read_reg(ADDR_STATUS, rd);
        check_word("status after reset", rd, '0);
        for (int w = 0; w < ELEM_WORDS; w++) begin
            read_reg(ADDR_RES_BASE + 8'(4 * w), rd);
            check_word($sformatf("result word %0d after reset", w), rd, '0);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        check_error_responses();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/sm2_red_pkg.sv
src/sm2_red_ctrl.sv
src/sm2_word_fold.sv
src/sm2_coarse_reduce.sv
src/sm2_final_correct.sv
src/sm2_red_top.sv
bench/sm2_red_clkgen.sv
bench/sm2_red_chk.sv
bench/sm2_red_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= sm2_red_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qFx '** PASS **' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
